/* design/scope_cfg_pkg.sv */
// address map, field widths, reset defaults and bus, control and settings types
package scope_cfg_pkg;

  localparam int N_CH   = 2;
  localparam int ADC_DW = 14;  // wrapped sample width
  localparam int DEC_W  = 17;
  localparam int ADDR_W = 20;

  // register map
  localparam logic [ADDR_W-1:0] ADR_CTRL        = 'h000;
  localparam logic [ADDR_W-1:0] ADR_TRG_SRC     = 'h004;
  localparam logic [ADDR_W-1:0] ADR_TRESH0      = 'h008;
  localparam logic [ADDR_W-1:0] ADR_TRESH1      = 'h00C;
  localparam logic [ADDR_W-1:0] ADR_DLY0        = 'h010;
  localparam logic [ADDR_W-1:0] ADR_DEC0        = 'h014;
  localparam logic [ADDR_W-1:0] ADR_WP_CUR0     = 'h018;
  localparam logic [ADDR_W-1:0] ADR_WP_TRIG0    = 'h01C;
  localparam logic [ADDR_W-1:0] ADR_HYST0       = 'h020;
  localparam logic [ADDR_W-1:0] ADR_HYST1       = 'h024;
  localparam logic [ADDR_W-1:0] ADR_WE_CNT0     = 'h02C;
  localparam logic [ADDR_W-1:0] ADR_TRIG_UNLOCK = 'h094;
  localparam logic [ADDR_W-1:0] ADR_DLY1        = 'h110;
  localparam logic [ADDR_W-1:0] ADR_DEC1        = 'h114;
  localparam logic [ADDR_W-1:0] ADR_WP_CUR1     = 'h118;
  localparam logic [ADDR_W-1:0] ADR_WP_TRIG1    = 'h11C;
  localparam logic [ADDR_W-1:0] ADR_WE_CNT1     = 'h12C;

  // capture buffer windows, matched on the top nibble
  localparam logic [ADDR_W-1:0] BUF_BASE0       = 'h10000;
  localparam logic [ADDR_W-1:0] BUF_BASE1       = 'h20000;

  localparam logic [ADC_DW-1:0] DEF_TRESH0 = ADC_DW'(5000);
  localparam logic [ADC_DW-1:0] DEF_TRESH1 = ADC_DW'(-5000);
  localparam logic [31:0]       DEF_DLY    = 32'd0;
  localparam logic [DEC_W-1:0]  DEF_DEC    = DEC_W'(1);
  localparam logic [ADC_DW-1:0] DEF_HYST   = ADC_DW'(20);

  // one control byte lane, low nibble doubles as trigger source
  typedef struct packed {
    logic [1:0] rsvd_hi;
    logic       indep;    // independent acquisition
    logic       rsvd_4;
    logic       keep;     // stay armed after trigger
    logic       rsvd_2;
    logic       rst;
    logic       arm;
  } ctrl_byte_t;

  typedef union packed {
    logic [31:0]          word;
    ctrl_byte_t [3:0]     lane;  // one lane per channel
  } sys_word_u;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    sys_word_u         wdata;
    logic              wen;
    logic              ren;
  } sys_bus_t;

  // write strobes, wen already folded in
  typedef struct packed {
    logic            ctrl;
    logic            trg_src;
    logic            unlock;
    logic [N_CH-1:0] tresh;
    logic [N_CH-1:0] dly;
    logic [N_CH-1:0] dec;
    logic [N_CH-1:0] hyst;
  } wr_sel_t;

  typedef enum logic [4:0] {
    RD_ZERO, RD_ADC_STATE, RD_TRG_STATE,
    RD_TRESH0, RD_TRESH1, RD_DLY0, RD_DLY1, RD_DEC0, RD_DEC1, RD_HYST0, RD_HYST1,
    RD_WP_CUR0, RD_WP_CUR1, RD_WP_TRIG0, RD_WP_TRIG1, RD_WE_CNT0, RD_WE_CNT1,
    RD_BUF0, RD_BUF1
  } rd_src_e;

  typedef struct packed {
    logic       arm_do;
    logic       rst_do;
    logic       trig_sw;
    logic       we_keep;
    logic       trig_dis_clr;
    logic       new_trg_src;
    logic [3:0] trg_src;
  } acq_ctrl_t;

  typedef struct packed {
    logic [ADC_DW-1:0] tresh;
    logic [31:0]       dly;
    logic [DEC_W-1:0]  dec;
    logic              dec1;  // decimation equals one
    logic [ADC_DW-1:0] hyst;
  } chan_set_t;

endpackage

/* design/sys_bus_decode.sv */
// address decoder turning bus requests into write strobes and a read source
`timescale 1ns/1ps

module sys_bus_decode import scope_cfg_pkg::*; (
  input  sys_bus_t sys_i,
  output wr_sel_t  wr_sel_o,
  output rd_src_e  rd_src_o
);

  localparam int NIB_LSB = ADDR_W - 4;

  logic [ADDR_W-1:0] addr;
  logic              wen;
  logic              buf0_hit;
  logic              buf1_hit;

  assign addr     = sys_i.addr;
  assign wen      = sys_i.wen;
  assign buf0_hit = addr[ADDR_W-1:NIB_LSB] == BUF_BASE0[ADDR_W-1:NIB_LSB];
  assign buf1_hit = addr[ADDR_W-1:NIB_LSB] == BUF_BASE1[ADDR_W-1:NIB_LSB];

  always_comb begin
    wr_sel_o.ctrl     = wen && (addr == ADR_CTRL);
    wr_sel_o.trg_src  = wen && (addr == ADR_TRG_SRC);
    wr_sel_o.unlock   = wen && (addr == ADR_TRIG_UNLOCK);
    wr_sel_o.tresh[0] = wen && (addr == ADR_TRESH0);
    wr_sel_o.tresh[1] = wen && (addr == ADR_TRESH1);
    wr_sel_o.dly[0]   = wen && (addr == ADR_DLY0);
    wr_sel_o.dly[1]   = wen && (addr == ADR_DLY1);
    wr_sel_o.dec[0]   = wen && (addr == ADR_DEC0);
    wr_sel_o.dec[1]   = wen && (addr == ADR_DEC1);
    wr_sel_o.hyst[0]  = wen && (addr == ADR_HYST0);
    wr_sel_o.hyst[1]  = wen && (addr == ADR_HYST1);
  end

  always_comb begin
    rd_src_o = RD_ZERO;
    case (addr)
      ADR_CTRL:     rd_src_o = RD_ADC_STATE;  // status words share the control slots
      ADR_TRG_SRC:  rd_src_o = RD_TRG_STATE;
      ADR_TRESH0:   rd_src_o = RD_TRESH0;
      ADR_TRESH1:   rd_src_o = RD_TRESH1;
      ADR_DLY0:     rd_src_o = RD_DLY0;
      ADR_DLY1:     rd_src_o = RD_DLY1;
      ADR_DEC0:     rd_src_o = RD_DEC0;
      ADR_DEC1:     rd_src_o = RD_DEC1;
      ADR_HYST0:    rd_src_o = RD_HYST0;
      ADR_HYST1:    rd_src_o = RD_HYST1;
      ADR_WP_CUR0:  rd_src_o = RD_WP_CUR0;
      ADR_WP_CUR1:  rd_src_o = RD_WP_CUR1;
      ADR_WP_TRIG0: rd_src_o = RD_WP_TRIG0;
      ADR_WP_TRIG1: rd_src_o = RD_WP_TRIG1;
      ADR_WE_CNT0:  rd_src_o = RD_WE_CNT0;
      ADR_WE_CNT1:  rd_src_o = RD_WE_CNT1;
      default: begin
        if (buf0_hit) begin
          rd_src_o = RD_BUF0;
        end else if (buf1_hit) begin
          rd_src_o = RD_BUF1;
        end
      end
    endcase
  end

endmodule

/* design/acq_ctrl_regs.sv */
// per-channel acquisition control and trigger source registers with their pulses
`timescale 1ns/1ps

module acq_ctrl_regs import scope_cfg_pkg::*; (
  input  logic                  adc_clk_i,
  input  logic                  adc_rstn_i,
  input  wr_sel_t               wr_sel_i,
  input  sys_word_u             wdata_i,
  output acq_ctrl_t [N_CH-1:0]  ctrl_raw_o,
  output logic      [N_CH-1:0]  indep_mode_o
);

  for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
    ctrl_byte_t lane;
    logic [3:0] src_nib;
    logic       lane_set;
    acq_ctrl_t  ctrl_q;
    logic       indep_q;

    assign lane     = wdata_i.lane[ch];  // own byte lane per channel
    assign src_nib  = lane[3:0];
    assign lane_set = lane != '0;

    always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
        ctrl_q  <= '0;
        indep_q <= 1'b0;
      end else begin
        // single cycle strobes
        ctrl_q.arm_do       <= wr_sel_i.ctrl && lane.arm;
        ctrl_q.rst_do       <= wr_sel_i.ctrl && lane.rst;
        ctrl_q.trig_sw      <= wr_sel_i.trg_src && (src_nib == 4'h1);  // sw trigger
        ctrl_q.new_trg_src  <= wr_sel_i.trg_src && lane_set;
        ctrl_q.trig_dis_clr <= wr_sel_i.unlock && wdata_i.word[0];

        if (wr_sel_i.ctrl && lane_set) begin
          ctrl_q.we_keep <= lane.keep;
          indep_q        <= lane.indep;
        end
        if (wr_sel_i.trg_src && lane_set) begin
          ctrl_q.trg_src <= src_nib;  // zero lane leaves source alone
        end
      end
    end

    assign ctrl_raw_o[ch]   = ctrl_q;
    assign indep_mode_o[ch] = indep_q;
  end

endmodule

/* design/chan_settings_regs.sv */
// per-channel threshold, delay, decimation and hysteresis setting registers
`timescale 1ns/1ps

module chan_settings_regs import scope_cfg_pkg::*; (
  input  logic                  adc_clk_i,
  input  logic                  adc_rstn_i,
  input  wr_sel_t               wr_sel_i,
  input  sys_word_u             wdata_i,
  output chan_set_t [N_CH-1:0]  set_raw_o
);

  logic [31:0] wword;

  assign wword = wdata_i.word;

  for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
    localparam logic [ADC_DW-1:0] TRESH_RST = (ch == 0) ? DEF_TRESH0 : DEF_TRESH1;

    chan_set_t set_q;

    always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
        set_q.tresh <= TRESH_RST;
        set_q.dly   <= DEF_DLY;
        set_q.dec   <= DEF_DEC;
        set_q.dec1  <= DEF_DEC == DEC_W'(1);
        set_q.hyst  <= DEF_HYST;
      end else begin
        if (wr_sel_i.tresh[ch]) begin
          set_q.tresh <= wword[ADC_DW-1:0];
        end
        if (wr_sel_i.dly[ch]) begin
          set_q.dly <= wword;
        end
        // flag tracks the new value, no extra cycle
        if (wr_sel_i.dec[ch]) begin
          set_q.dec  <= wword[DEC_W-1:0];
          set_q.dec1 <= wword[DEC_W-1:0] == DEC_W'(1);
        end
        if (wr_sel_i.hyst[ch]) begin
          set_q.hyst <= wword[ADC_DW-1:0];
        end
      end
    end

    assign set_raw_o[ch] = set_q;
  end

endmodule

/* design/chan_link_mux.sv */
// linked mode mux, later channels copy channel 0 unless set independent
`timescale 1ns/1ps

module chan_link_mux import scope_cfg_pkg::*; (
  input  acq_ctrl_t [N_CH-1:0]  ctrl_raw_i,
  input  chan_set_t [N_CH-1:0]  set_raw_i,
  input  logic      [N_CH-1:0]  indep_mode_i,
  output acq_ctrl_t [N_CH-1:0]  acq_ctrl_o,
  output chan_set_t [N_CH-1:0]  chan_set_o
);

  always_comb begin
    acq_ctrl_o = ctrl_raw_i;
    chan_set_o = set_raw_i;
    for (int ch = 1; ch < N_CH; ch++) begin
      if (!indep_mode_i[ch]) begin
        acq_ctrl_o[ch]      = ctrl_raw_i[0];  // pulses, source and keep
        chan_set_o[ch].dly  = set_raw_i[0].dly;
        chan_set_o[ch].dec  = set_raw_i[0].dec;
        chan_set_o[ch].dec1 = set_raw_i[0].dec1;
        // tresh and hyst stay per channel
      end
    end
  end

endmodule

/* design/read_return.sv */
// read data selector with registered data and acknowledge
`timescale 1ns/1ps

module read_return import scope_cfg_pkg::*; #(
  parameter int RSZ = 14  // buffer pointer width
) (
  input  logic                    adc_clk_i,
  input  logic                    adc_rstn_i,
  input  rd_src_e                 rd_src_i,
  input  logic                    sys_en_i,
  input  chan_set_t [N_CH-1:0]    set_raw_i,
  input  logic [31:0]             adc_state_i,
  input  logic [31:0]             trg_state_i,
  input  logic [N_CH*RSZ-1:0]     adc_wp_cur_i,
  input  logic [N_CH*RSZ-1:0]     adc_wp_trig_i,
  input  logic [N_CH*32-1:0]      adc_we_cnt_i,
  input  logic [N_CH*ADC_DW-1:0]  bram_rd_dat_i,
  input  logic [N_CH-1:0]         bram_ack_i,
  output logic [31:0]             sys_rdata_o,
  output logic                    sys_ack_o
);

  logic [31:0] rdata_nxt;
  logic        ack_nxt;

  always_comb begin
    rdata_nxt = '0;
    ack_nxt   = sys_en_i;  // registers answer at once
    case (rd_src_i)
      RD_ADC_STATE: rdata_nxt = adc_state_i;
      RD_TRG_STATE: rdata_nxt = trg_state_i;
      RD_TRESH0:    rdata_nxt = 32'(set_raw_i[0].tresh);
      RD_TRESH1:    rdata_nxt = 32'(set_raw_i[1].tresh);
      RD_DLY0:      rdata_nxt = set_raw_i[0].dly;
      RD_DLY1:      rdata_nxt = set_raw_i[1].dly;
      RD_DEC0:      rdata_nxt = 32'(set_raw_i[0].dec);
      RD_DEC1:      rdata_nxt = 32'(set_raw_i[1].dec);
      RD_HYST0:     rdata_nxt = 32'(set_raw_i[0].hyst);
      RD_HYST1:     rdata_nxt = 32'(set_raw_i[1].hyst);
      RD_WP_CUR0:   rdata_nxt = 32'(adc_wp_cur_i[0 +: RSZ]);
      RD_WP_CUR1:   rdata_nxt = 32'(adc_wp_cur_i[RSZ +: RSZ]);
      RD_WP_TRIG0:  rdata_nxt = 32'(adc_wp_trig_i[0 +: RSZ]);
      RD_WP_TRIG1:  rdata_nxt = 32'(adc_wp_trig_i[RSZ +: RSZ]);
      RD_WE_CNT0:   rdata_nxt = adc_we_cnt_i[0 +: 32];
      RD_WE_CNT1:   rdata_nxt = adc_we_cnt_i[32 +: 32];
      // buffer reads wait for the memory, address held until ack
      RD_BUF0: begin
        rdata_nxt = 32'(bram_rd_dat_i[0 +: ADC_DW]);
        ack_nxt   = bram_ack_i[0];
      end
      RD_BUF1: begin
        rdata_nxt = 32'(bram_rd_dat_i[ADC_DW +: ADC_DW]);
        ack_nxt   = bram_ack_i[1];
      end
      default:      rdata_nxt = '0;
    endcase
  end

  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      sys_ack_o <= 1'b0;
    end else begin
      sys_ack_o <= ack_nxt;
    end
  end

  always_ff @(posedge adc_clk_i) begin
    sys_rdata_o <= rdata_nxt;
  end

endmodule

/* design/scope_cfg_top.sv */
// register block top with decoder, control and settings peers, link mux and read return
`timescale 1ns/1ps

module scope_cfg_top import scope_cfg_pkg::*; #(
  parameter int RSZ = 14
) (
  input  logic                    adc_clk_i,
  input  logic                    adc_rstn_i,
  input  sys_bus_t                sys_i,
  input  logic [31:0]             adc_state_i,
  input  logic [31:0]             trg_state_i,
  input  logic [N_CH*RSZ-1:0]     adc_wp_cur_i,
  input  logic [N_CH*RSZ-1:0]     adc_wp_trig_i,
  input  logic [N_CH*32-1:0]      adc_we_cnt_i,
  input  logic [N_CH*ADC_DW-1:0]  bram_rd_dat_i,
  input  logic [N_CH-1:0]         bram_ack_i,
  output logic [31:0]             sys_rdata_o,
  output logic                    sys_ack_o,
  output acq_ctrl_t [N_CH-1:0]    acq_ctrl_o,
  output chan_set_t [N_CH-1:0]    chan_set_o,
  output logic [N_CH-1:0]         indep_mode_o
);

  wr_sel_t              wr_sel;
  rd_src_e              rd_src;
  acq_ctrl_t [N_CH-1:0] ctrl_raw;
  chan_set_t [N_CH-1:0] set_raw;
  logic      [N_CH-1:0] indep_mode;
  logic                 sys_en;

  assign sys_en       = sys_i.wen | sys_i.ren;
  assign indep_mode_o = indep_mode;

  sys_bus_decode sys_bus_decode_inst (
    .sys_i    (sys_i),
    .wr_sel_o (wr_sel),
    .rd_src_o (rd_src)
  );

  acq_ctrl_regs acq_ctrl_regs_inst (
    .adc_clk_i    (adc_clk_i),
    .adc_rstn_i   (adc_rstn_i),
    .wr_sel_i     (wr_sel),
    .wdata_i      (sys_i.wdata),
    .ctrl_raw_o   (ctrl_raw),
    .indep_mode_o (indep_mode)
  );

  chan_settings_regs chan_settings_regs_inst (
    .adc_clk_i  (adc_clk_i),
    .adc_rstn_i (adc_rstn_i),
    .wr_sel_i   (wr_sel),
    .wdata_i    (sys_i.wdata),
    .set_raw_o  (set_raw)
  );

  chan_link_mux chan_link_mux_inst (
    .ctrl_raw_i   (ctrl_raw),
    .set_raw_i    (set_raw),
    .indep_mode_i (indep_mode),
    .acq_ctrl_o   (acq_ctrl_o),
    .chan_set_o   (chan_set_o)
  );

  read_return #(
    .RSZ (RSZ)
  ) read_return_inst (
    .adc_clk_i     (adc_clk_i),
    .adc_rstn_i    (adc_rstn_i),
    .rd_src_i      (rd_src),
    .sys_en_i      (sys_en),
    .set_raw_i     (set_raw),  // readback shows raw, not linked, values
    .adc_state_i   (adc_state_i),
    .trg_state_i   (trg_state_i),
    .adc_wp_cur_i  (adc_wp_cur_i),
    .adc_wp_trig_i (adc_wp_trig_i),
    .adc_we_cnt_i  (adc_we_cnt_i),
    .bram_rd_dat_i (bram_rd_dat_i),
    .bram_ack_i    (bram_ack_i),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o)
  );

endmodule

/* bench/scope_cfg_properties.sv */
// bound assertions on pulse width, register ack timing and reset state
`timescale 1ns/1ps

module scope_cfg_properties (
  input logic        adc_clk_i,
  input logic        adc_rstn_i,
  input logic        req_i,    // register-source request
  input logic        ack_i,
  input logic [9:0]  pulse_i,
  input logic [11:0] held_i
);

  a_pulse_one_cycle: assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
    (pulse_i != '0) |=> ((pulse_i & $past(pulse_i)) == '0))
    else $error("control pulse held longer than one cycle");

  a_reg_ack: assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
    req_i |=> ack_i)
    else $error("register request not acknowledged on the next cycle");

  a_reset_low: assert property (@(posedge adc_clk_i)
    !adc_rstn_i |=> (!ack_i && pulse_i == '0 && held_i == '0))
    else $error("outputs not low after reset");

endmodule

bind read_return scope_cfg_properties ret_props_inst (
  .adc_clk_i  (adc_clk_i),
  .adc_rstn_i (adc_rstn_i),
  .req_i      (sys_en_i && rd_src_i != scope_cfg_pkg::RD_BUF0
               && rd_src_i != scope_cfg_pkg::RD_BUF1),
  .ack_i      (sys_ack_o),
  .pulse_i    (10'b0),
  .held_i     (12'b0)
);

bind acq_ctrl_regs scope_cfg_properties ctrl_props_inst (
  .adc_clk_i  (adc_clk_i),
  .adc_rstn_i (adc_rstn_i),
  .req_i      (1'b0),
  .ack_i      (1'b0),
  .pulse_i    ({ctrl_raw_o[1].arm_do, ctrl_raw_o[1].rst_do, ctrl_raw_o[1].trig_sw,
                ctrl_raw_o[1].trig_dis_clr, ctrl_raw_o[1].new_trg_src,
                ctrl_raw_o[0].arm_do, ctrl_raw_o[0].rst_do, ctrl_raw_o[0].trig_sw,
                ctrl_raw_o[0].trig_dis_clr, ctrl_raw_o[0].new_trg_src}),
  .held_i     ({ctrl_raw_o[1].we_keep, ctrl_raw_o[1].trg_src,
                ctrl_raw_o[0].we_keep, ctrl_raw_o[0].trg_src, indep_mode_o})
);

/* bench/scope_cfg_tb.sv */
// testbench with bus tasks, shadow reference model, compare process and report
`timescale 1ns/1ps

module scope_cfg_tb import scope_cfg_pkg::*; ();

  localparam int RSZ         = 14;
  localparam int WP_W        = N_CH * RSZ;
  localparam int TIMEOUT_CYC = 4000;  // about 100 accesses of three to ten cycles

  logic                   clk;
  logic                   rstn;
  sys_bus_t               sys;
  logic [31:0]            adc_state, trg_state, rdata;
  logic [N_CH*RSZ-1:0]    wp_cur, wp_trig;
  logic [N_CH*32-1:0]     we_cnt;
  logic [N_CH*ADC_DW-1:0] bram_dat;
  logic [N_CH-1:0]        bram_ack, indep_mode;
  logic                   ack;
  acq_ctrl_t [N_CH-1:0]   acq_ctrl, snap1, snap2;
  chan_set_t [N_CH-1:0]   chan_set;

  // shadow copy of the register state
  logic [ADC_DW-1:0] sh_tresh [N_CH];
  logic [31:0]       sh_dly   [N_CH];
  logic [DEC_W-1:0]  sh_dec   [N_CH];
  logic [ADC_DW-1:0] sh_hyst  [N_CH];
  acq_ctrl_t         sh_ctrl  [N_CH];
  logic [N_CH-1:0]   sh_indep;

  logic [32:0] exp_q [$];
  string       name_q [$];
  logic [32:0] exp_e;
  int seed, cyc, ack_cyc, raise_cyc, err_cnt, err_base, tests_run, tests_failed;

  scope_cfg_top #(.RSZ(RSZ)) scope_cfg_top_inst (
    .adc_clk_i (clk), .adc_rstn_i (rstn), .sys_i (sys),
    .adc_state_i (adc_state), .trg_state_i (trg_state),
    .adc_wp_cur_i (wp_cur), .adc_wp_trig_i (wp_trig), .adc_we_cnt_i (we_cnt),
    .bram_rd_dat_i (bram_dat), .bram_ack_i (bram_ack),
    .sys_rdata_o (rdata), .sys_ack_o (ack),
    .acq_ctrl_o (acq_ctrl), .chan_set_o (chan_set), .indep_mode_o (indep_mode)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic check(string name, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // every ack retires the oldest request and compares reads
  always @(negedge clk) begin
    if (rstn && ack) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("Error: acknowledge seen with no request outstanding");
      end else begin
        exp_e = exp_q.pop_front();
        if (exp_e[32]) check(name_q.pop_front(), 128'(rdata), 128'(exp_e[31:0]));
        else void'(name_q.pop_front());
      end
    end
  end

  function automatic logic [31:0] ref_read(logic [ADDR_W-1:0] a);
    case (a)
      ADR_CTRL:     return adc_state;
      ADR_TRG_SRC:  return trg_state;
      ADR_TRESH0:   return 32'(sh_tresh[0]);
      ADR_TRESH1:   return 32'(sh_tresh[1]);
      ADR_DLY0:     return sh_dly[0];
      ADR_DLY1:     return sh_dly[1];
      ADR_DEC0:     return 32'(sh_dec[0]);
      ADR_DEC1:     return 32'(sh_dec[1]);
      ADR_HYST0:    return 32'(sh_hyst[0]);
      ADR_HYST1:    return 32'(sh_hyst[1]);
      ADR_WP_CUR0:  return 32'(wp_cur[RSZ-1:0]);
      ADR_WP_CUR1:  return 32'(wp_cur[2*RSZ-1:RSZ]);
      ADR_WP_TRIG0: return 32'(wp_trig[RSZ-1:0]);
      ADR_WP_TRIG1: return 32'(wp_trig[2*RSZ-1:RSZ]);
      ADR_WE_CNT0:  return we_cnt[31:0];
      ADR_WE_CNT1:  return we_cnt[63:32];
      default: begin
        if (a[ADDR_W-1:ADDR_W-4] == BUF_BASE0[ADDR_W-1:ADDR_W-4])
          return 32'(bram_dat[ADC_DW-1:0]);
        if (a[ADDR_W-1:ADDR_W-4] == BUF_BASE1[ADDR_W-1:ADDR_W-4])
          return 32'(bram_dat[2*ADC_DW-1:ADC_DW]);
        return 32'd0;
      end
    endcase
  endfunction

  // expected settings after the link rules
  function automatic chan_set_t set_ref(int ch);
    chan_set_t s;
    int src;
    src     = (ch > 0 && !sh_indep[ch]) ? 0 : ch;
    s.tresh = sh_tresh[ch];
    s.hyst  = sh_hyst[ch];
    s.dly   = sh_dly[src];
    s.dec   = sh_dec[src];
    s.dec1  = sh_dec[src] == DEC_W'(1);
    return s;
  endfunction

  function automatic acq_ctrl_t held_only(acq_ctrl_t c);
    c.arm_do       = 1'b0;
    c.rst_do       = 1'b0;
    c.trig_sw      = 1'b0;
    c.trig_dis_clr = 1'b0;
    c.new_trg_src  = 1'b0;
    return c;
  endfunction

  // raw control state of one channel right after a write
  function automatic acq_ctrl_t raw_ctrl(int ch, logic [ADDR_W-1:0] a, logic [31:0] w);
    acq_ctrl_t r;
    logic [7:0] lane;
    lane = w[8*ch +: 8];
    r    = sh_ctrl[ch];
    if (a == ADR_CTRL) begin
      r.arm_do = lane[0];
      r.rst_do = lane[1];
      if (lane != 8'h0) r.we_keep = lane[3];
    end
    if (a == ADR_TRG_SRC) begin
      r.trig_sw     = lane[3:0] == 4'h1;
      r.new_trg_src = lane != 8'h0;
      if (lane != 8'h0) r.trg_src = lane[3:0];
    end
    if (a == ADR_TRIG_UNLOCK) r.trig_dis_clr = w[0];
    return r;
  endfunction

  task automatic bus_access(logic [ADDR_W-1:0] a, logic [31:0] w, logic wr);
    @(posedge clk);
    sys.addr       <= a;
    sys.wdata.word <= w;
    sys.wen        <= wr;
    sys.ren        <= ~wr;
    exp_q.push_back({~wr, ref_read(a)});
    name_q.push_back($sformatf("sys_rdata_o @0x%05h", a));
    @(posedge clk);
    sys.wen <= 1'b0;
    sys.ren <= 1'b0;
    @(negedge clk);
    snap1 = acq_ctrl;  // cycle after the write edge
    while (!ack) @(negedge clk);
    ack_cyc = cyc;
    @(negedge clk);
    snap2 = acq_ctrl;
  endtask

  task automatic set_write(logic [ADDR_W-1:0] a, logic [31:0] w);
    case (a)
      ADR_TRESH0: sh_tresh[0] = w[ADC_DW-1:0];
      ADR_TRESH1: sh_tresh[1] = w[ADC_DW-1:0];
      ADR_DLY0:   sh_dly[0]   = w;
      ADR_DLY1:   sh_dly[1]   = w;
      ADR_DEC0:   sh_dec[0]   = w[DEC_W-1:0];
      ADR_DEC1:   sh_dec[1]   = w[DEC_W-1:0];
      ADR_HYST0:  sh_hyst[0]  = w[ADC_DW-1:0];
      ADR_HYST1:  sh_hyst[1]  = w[ADC_DW-1:0];
      default:    ;
    endcase
    bus_access(a, w, 1'b1);
  endtask

  task automatic ctrl_write(logic [ADDR_W-1:0] a, logic [31:0] w);
    acq_ctrl_t raw [N_CH];
    acq_ctrl_t exp_p, exp_h;
    for (int ch = 0; ch < N_CH; ch++) raw[ch] = raw_ctrl(ch, a, w);
    for (int ch = 0; ch < N_CH; ch++) begin
      sh_ctrl[ch] = held_only(raw[ch]);
      if (a == ADR_CTRL && w[8*ch +: 8] != 8'h0) sh_indep[ch] = w[8*ch+5];
    end
    bus_access(a, w, 1'b1);
    for (int ch = 0; ch < N_CH; ch++) begin
      exp_p = (ch > 0 && !sh_indep[ch]) ? raw[0] : raw[ch];
      exp_h = held_only(exp_p);
      check($sformatf("acq_ctrl_o[%0d] pulse cycle", ch), 128'(snap1[ch]), 128'(exp_p));
      check($sformatf("acq_ctrl_o[%0d] following cycle", ch), 128'(snap2[ch]), 128'(exp_h));
    end
    check("indep_mode_o", 128'(indep_mode), 128'(sh_indep));
  endtask

  task automatic check_settings();
    for (int ch = 0; ch < N_CH; ch++)
      check($sformatf("chan_set_o[%0d]", ch), 128'(chan_set[ch]), 128'(set_ref(ch)));
  endtask

  task automatic read_all_settings();
    bus_access(ADR_TRESH0, 32'd0, 1'b0);
    bus_access(ADR_TRESH1, 32'd0, 1'b0);
    bus_access(ADR_DLY0, 32'd0, 1'b0);
    bus_access(ADR_DLY1, 32'd0, 1'b0);
    bus_access(ADR_DEC0, 32'd0, 1'b0);
    bus_access(ADR_DEC1, 32'd0, 1'b0);
    bus_access(ADR_HYST0, 32'd0, 1'b0);
    bus_access(ADR_HYST1, 32'd0, 1'b0);
  endtask

  task automatic raise_buf_ack(int ch, int d);
    repeat (d) @(posedge clk);
    bram_ack[ch] <= 1'b1;
    @(negedge clk);
    raise_cyc = cyc;
    @(posedge clk);
    bram_ack[ch] <= 1'b0;
  endtask

  task automatic start_test();
    err_base = err_cnt;
    tests_run++;
  endtask

  task automatic end_test(string name);
    if (err_cnt == err_base) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, err_cnt - err_base);
    end
  endtask

  initial begin
    logic [31:0] rv;
    int d;
    seed = 32'h9aad_4352;
    {cyc, err_cnt, err_base, tests_run, tests_failed} = '0;
    rstn      = 1'b0;
    sys       = '0;
    adc_state = 32'h0001_2345;
    trg_state = 32'h0000_0042;
    wp_cur    = '0;
    wp_trig   = '0;
    we_cnt    = '0;
    bram_dat  = '0;
    bram_ack  = '0;
    for (int ch = 0; ch < N_CH; ch++) begin
      sh_tresh[ch] = (ch == 0) ? DEF_TRESH0 : DEF_TRESH1;
      sh_dly[ch]   = DEF_DLY;
      sh_dec[ch]   = DEF_DEC;
      sh_hyst[ch]  = DEF_HYST;
      sh_ctrl[ch]  = '0;
    end
    sh_indep = '0;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;

    start_test();
    read_all_settings();
    bus_access(20'h00030, 32'd0, 1'b0);
    bus_access(20'h00200, 32'd0, 1'b0);
    bus_access(20'h30000, 32'd0, 1'b0);
    check_settings();
    end_test("reset defaults");

    start_test();
    ctrl_write(ADR_CTRL, 32'h0000_2020);  // both channels independent
    for (int k = 0; k < 4; k++) begin
      for (int ch = 0; ch < N_CH; ch++) begin
        rv = $random(seed);
        set_write(ch == 0 ? ADR_TRESH0 : ADR_TRESH1, rv);
        rv = $random(seed);
        set_write(ch == 0 ? ADR_DLY0 : ADR_DLY1, rv);
        rv = (k == 1) ? 32'd1 : $random(seed);
        set_write(ch == 0 ? ADR_DEC0 : ADR_DEC1, rv);
        rv = $random(seed);
        set_write(ch == 0 ? ADR_HYST0 : ADR_HYST1, rv);
      end
      read_all_settings();
      check_settings();
    end
    end_test("settings write and readback");

    start_test();
    ctrl_write(ADR_CTRL, 32'h0000_2A21);
    ctrl_write(ADR_TRG_SRC, 32'h0000_0301);
    ctrl_write(ADR_TRG_SRC, 32'h0000_0005);  // channel 1 lane zero
    ctrl_write(ADR_TRIG_UNLOCK, 32'h0000_0001);
    ctrl_write(ADR_CTRL, 32'h0000_2023);
    end_test("independent control pulses");

    start_test();
    ctrl_write(ADR_CTRL, 32'h0000_0828);
    ctrl_write(ADR_CTRL, 32'h0000_0029);
    ctrl_write(ADR_TRG_SRC, 32'h0000_0201);
    ctrl_write(ADR_TRIG_UNLOCK, 32'h0000_0001);
    rv = $random(seed);
    set_write(ADR_DLY0, rv);
    rv = $random(seed);
    set_write(ADR_DEC0, rv);
    rv = $random(seed);
    set_write(ADR_TRESH1, rv);
    check_settings();
    end_test("linked mode");

    start_test();
    @(posedge clk);
    adc_state <= $random(seed);
    trg_state <= $random(seed);
    wp_cur    <= WP_W'($random(seed));
    wp_trig   <= WP_W'($random(seed));
    we_cnt    <= {$random(seed), $random(seed)};
    bus_access(ADR_CTRL, 32'd0, 1'b0);
    bus_access(ADR_TRG_SRC, 32'd0, 1'b0);
    bus_access(ADR_WP_CUR0, 32'd0, 1'b0);
    bus_access(ADR_WP_CUR1, 32'd0, 1'b0);
    bus_access(ADR_WP_TRIG0, 32'd0, 1'b0);
    bus_access(ADR_WP_TRIG1, 32'd0, 1'b0);
    bus_access(ADR_WE_CNT0, 32'd0, 1'b0);
    bus_access(ADR_WE_CNT1, 32'd0, 1'b0);
    for (int ch = 0; ch < N_CH; ch++) begin
      rv = $random(seed);
      @(posedge clk);
      bram_dat <= {rv[13:0], rv[29:16]};
      d = 2 + int'($unsigned($random(seed)) % 5);
      rv = $random(seed);
      fork
        bus_access((ch == 0 ? BUF_BASE0 : BUF_BASE1) + {4'h0, rv[15:0]}, 32'd0, 1'b0);
        raise_buf_ack(ch, d);
      join
      check("sys_ack_o delay after bram_ack_i", 128'(ack_cyc - raise_cyc), 128'(1));
    end
    end_test("status and buffer reads");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* tb.f */
design/scope_cfg_pkg.sv
design/sys_bus_decode.sv
design/acq_ctrl_regs.sv
design/chan_settings_regs.sv
design/chan_link_mux.sv
design/read_return.sv
design/scope_cfg_top.sv
bench/scope_cfg_properties.sv
bench/scope_cfg_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module scope_cfg_tb -o scope_cfg_sim &&
./obj_dir/scope_cfg_sim | tee /dev/stderr | grep -q "All tests passed!" &&
echo "run_sim: simulation ok" ||
{ echo "run_sim: simulation failed"; exit 1; }
